// File: src.f
+incdir+verification
common/fpga_regs_pkg.sv
fifo/fifo_level_flags.sv
fifo/sync_fifo.sv
fpga_registers/fpga_registers.sv
hw/fpga_subsystem_top.sv
verification/fpga_subsystem_asserts.sv
verification/tb_fpga_subsystem.sv

// File: verification/tb_fpga_vectors.svh
//----------------------------------------------------------------------
// Bus access vectors
//----------------------------------------------------------------------
`ifndef TB_FPGA_VECTORS_SVH
`define TB_FPGA_VECTORS_SVH

// Columns: address, write flag, byte strobe, write data, expected read value
typedef struct packed {
    logic [8:0]  adr;
    logic        we;
    logic [3:0]  byte_stb;
    logic [31:0] dat;
    logic [31:0] exp_val;   // Ignored on writes
} bus_vector_t;

localparam int          NUM_VECTORS  = 15;
localparam logic [7:0]  GPIO_OUT_EXP = 8'hA5;   // Final pin values after the table
localparam logic [7:0]  GPIO_OE_EXP  = 8'h3C;

function automatic bus_vector_t vector_row(input int idx);
    case (idx)
        0:  return {FIFO1_FLAG_ADR, 1'b0, 4'h0, 32'h0, flag_word_for(0, DEPTH1)};
        1:  return {FIFO2_FLAG_ADR, 1'b0, 4'h0, 32'h0, flag_word_for(0, DEPTH2)};
        2:  return {FIFO3_FLAG_ADR, 1'b0, 4'h0, 32'h0, flag_word_for(0, DEPTH3)};
        3:  return {GPIO_OUT_ADR,   1'b0, 4'h0, 32'h0, 32'h0000_0000};
        4:  return {GPIO_OE_ADR,    1'b0, 4'h0, 32'h0, 32'h0000_0000};
        5:  return {REG_ID_ADR,     1'b0, 4'h0, 32'h0, DEVICE_ID};
        6:  return {REG_REV_ADR,    1'b0, 4'h0, 32'h0, {16'h0000, REV_NUM}};
        7:  return {9'h005,         1'b0, 4'h0, 32'h0, DEFAULT_READ_VALUE};
        8:  return {9'h1FF,         1'b0, 4'h0, 32'h0, DEFAULT_READ_VALUE};
        9:  return {GPIO_OUT_ADR,   1'b1, 4'h1, 32'h0000_00A5, 32'h0};
        10: return {GPIO_OUT_ADR,   1'b0, 4'h0, 32'h0, {24'h0, GPIO_OUT_EXP}};
        11: return {GPIO_OE_ADR,    1'b1, 4'h1, 32'h0000_003C, 32'h0};
        12: return {GPIO_OE_ADR,    1'b0, 4'h0, 32'h0, {24'h0, GPIO_OE_EXP}};
        13: return {GPIO_OUT_ADR,   1'b1, 4'hE, 32'h0000_00FF, 32'h0};  // Byte 0 masked
        14: return {GPIO_OUT_ADR,   1'b0, 4'h0, 32'h0, {24'h0, GPIO_OUT_EXP}};
        default: return '0;
    endcase
endfunction

`endif

// File: verification/tb_fpga_subsystem.sv
//----------------------------------------------------------------------
// Register and FIFO subsystem testbench
//----------------------------------------------------------------------
module tb_fpga_subsystem;
    import fpga_regs_pkg::*;

    localparam int DEPTH1      = 8;
    localparam int DEPTH2      = 16;
    localparam int DEPTH3      = 8;
    localparam int ACK_TIMEOUT = 50;    // Cycles
    localparam int SEED        = 56152;

    logic        clk;
    logic        rst;
    logic [8:0]  adr;
    logic        cyc;
    logic        stb;
    logic        we;
    logic        rd;
    logic [3:0]  byte_stb;
    logic [31:0] dat_i;
    logic [31:0] dat_o;
    logic        ack;
    logic [7:0]  gpio_in;
    logic [7:0]  gpio_out;
    logic [7:0]  gpio_oe;

    int checks;
    int errors;
    int tests_run;
    int tests_failed;
    int assert_errors;

    fpga_subsystem_top #(
        .FIFO1_DEPTH (DEPTH1),
        .FIFO2_DEPTH (DEPTH2),
        .FIFO3_DEPTH (DEPTH3)
    ) uut (
        .WBs_CLK_i      (clk),
        .WBs_RST_i      (rst),
        .WBs_ADR_i      (adr),
        .WBs_CYC_i      (cyc),
        .WBs_BYTE_STB_i (byte_stb),
        .WBs_WE_i       (we),
        .WBs_RD_i       (rd),
        .WBs_STB_i      (stb),
        .WBs_DAT_i      (dat_i),
        .WBs_DAT_o      (dat_o),
        .WBs_ACK_o      (ack),
        .gpio_in_i      (gpio_in),
        .gpio_out_o     (gpio_out),
        .gpio_oe_o      (gpio_oe)
    );

    always #10 clk = ~clk;

    //------------------------------------------------------------------
    // Expected flag words
    //------------------------------------------------------------------
    function automatic logic [3:0] level_for(input int n, input int depth);
        logic [3:0] code;
        code = LVL_NONE;
        if (n > 0)
            code = LVL_SOME;
        if (4 * n >= depth)
            code = LVL_QUARTER;
        if (2 * n >= depth)
            code = LVL_HALF;
        if (4 * n >= 3 * depth)
            code = LVL_THREE_Q;
        if (n >= depth)
            code = LVL_ALL;
        return code;
    endfunction

    function automatic logic [31:0] flag_word_for(input int count, input int depth);
        int free;
        free = depth - count;
        return {16'h0000, (count <= 1), 3'b000, level_for(count, depth),
                (free <= 1), 3'b000, level_for(free, depth)};
    endfunction

    `include "tb_fpga_vectors.svh"

    //------------------------------------------------------------------
    // Checking and reporting
    //------------------------------------------------------------------
    task automatic compare_word(input string what, input logic [31:0] got,
                                input logic [31:0] exp);
        checks++;
        if (got !== exp)
        begin
            errors++;
            $display("ERR %0t: %s read %h, expected %h", $time, what, got, exp);
        end
    endtask

    task automatic report_test(input string name, input int start_errors);
        tests_run++;
        if (errors != start_errors)
        begin
            tests_failed++;
            $display("test %s: failed", name);
        end
        else
            $display("test %s: ok", name);
    endtask

    task automatic abort_run(input string why);
        $display("Run stopped at %0t: %s", $time, why);
        $display("TESTS FAILED");
        $finish;
    endtask

    //------------------------------------------------------------------
    // Bus access entered and left on a falling edge
    //------------------------------------------------------------------
    task automatic bus_cycle(input logic [8:0] a, input logic w, input logic [3:0] be,
                             input logic [31:0] d, output logic [31:0] rdat);
        int wait_cnt;
        wait_cnt = 0;
        rdat     = '0;
        adr      = a;
        we       = w;
        rd       = ~w;
        byte_stb = be;
        dat_i    = d;
        cyc      = 1'b1;
        stb      = 1'b1;
        while (!ack && wait_cnt < ACK_TIMEOUT)
        begin
            @(negedge clk);
            wait_cnt++;
        end
        if (!ack)
            abort_run($sformatf("no acknowledge for address %h", a));
        else
        begin
            rdat = dat_o;       // Still driven from the held address
            cyc  = 1'b0;
            stb  = 1'b0;
            we   = 1'b0;
            rd   = 1'b0;
            repeat (2) @(negedge clk);
        end
    endtask

    task automatic bus_write(input logic [8:0] a, input logic [31:0] d);
        logic [31:0] unused;
        bus_cycle(a, 1'b1, 4'hF, d, unused);
    endtask

    task automatic bus_read(input logic [8:0] a, output logic [31:0] rdat);
        bus_cycle(a, 1'b0, 4'h0, 32'h0, rdat);
    endtask

    //------------------------------------------------------------------
    // Tests
    //------------------------------------------------------------------
    task automatic run_vector_table();
        bus_vector_t v;
        logic [31:0] rdat;
        int          start;
        start = errors;
        for (int i = 0; i < NUM_VECTORS; i++)
        begin
            v = vector_row(i);
            bus_cycle(v.adr, v.we, v.byte_stb, v.dat, rdat);
            if (!v.we)
                compare_word($sformatf("vector %0d addr %h", i, v.adr), rdat, v.exp_val);
        end
        report_test("vector_table", start);
    endtask

    task automatic gpio_pin_test();
        logic [31:0] rdat;
        int          start;
        start = errors;
        compare_word("gpio_out pins", {24'h0, gpio_out}, {24'h0, GPIO_OUT_EXP});
        compare_word("gpio_oe pins", {24'h0, gpio_oe}, {24'h0, GPIO_OE_EXP});
        repeat (3)
        begin
            gpio_in = $urandom;
            bus_read(GPIO_IN_ADR, rdat);
            compare_word("gpio_in", rdat, {24'h0, gpio_in});
        end
        report_test("gpio_pins", start);
    endtask

    // Pops every queued word and compares in order
    task automatic drain_fifo(input logic [8:0] acc_adr, inout logic [31:0] model [$]);
        logic [31:0] rdat;
        while (model.size() > 0)
        begin
            bus_read(acc_adr, rdat);
            compare_word($sformatf("fifo data at %h", acc_adr), rdat, model.pop_front());
        end
    endtask

    task automatic fifo_order_test(input string name, input logic [8:0] acc_adr,
                                   input logic [31:0] mask, input int n_words);
        logic [31:0] model [$];
        logic [31:0] word;
        int          start;
        start = errors;
        for (int i = 0; i < n_words; i++)
        begin
            word = $urandom;
            model.push_back(word & mask);  // FIFO1 and FIFO2 keep the low half
            bus_write(acc_adr, word);
        end
        drain_fifo(acc_adr, model);
        report_test(name, start);
    endtask

    task automatic fifo2_flag_test();
        logic [31:0] model [$];
        logic [31:0] word;
        logic [31:0] rdat;
        int          start;
        start = errors;
        bus_read(FIFO2_FLAG_ADR, rdat);
        compare_word("fifo2 flags at 0", rdat, flag_word_for(0, DEPTH2));
        for (int n = 1; n <= DEPTH2; n++)
        begin
            word = $urandom;
            model.push_back(word & 32'h0000_FFFF);
            bus_write(FIFO2_ACC_ADR, word);
            bus_read(FIFO2_FLAG_ADR, rdat);
            compare_word($sformatf("fifo2 flags at %0d", n), rdat, flag_word_for(n, DEPTH2));
        end
        drain_fifo(FIFO2_ACC_ADR, model);
        bus_read(FIFO2_FLAG_ADR, rdat);
        compare_word("fifo2 flags drained", rdat, flag_word_for(0, DEPTH2));
        report_test("fifo2_flags", start);
    endtask

    task automatic fifo1_overflow_test();
        logic [31:0] model [$];
        logic [31:0] word;
        logic [31:0] rdat;
        int          start;
        start = errors;
        for (int i = 0; i < DEPTH1 + 2; i++)
        begin
            word = $urandom;
            if (i < DEPTH1)
                model.push_back(word & 32'h0000_FFFF);   // Last two are dropped
            bus_write(FIFO1_ACC_ADR, word);
        end
        bus_read(FIFO1_FLAG_ADR, rdat);
        compare_word("fifo1 flags full", rdat, flag_word_for(DEPTH1, DEPTH1));
        drain_fifo(FIFO1_ACC_ADR, model);
        bus_read(FIFO1_FLAG_ADR, rdat);
        compare_word("fifo1 flags drained", rdat, flag_word_for(0, DEPTH1));
        report_test("fifo1_overflow", start);
    endtask

    //------------------------------------------------------------------
    // Main sequence
    //------------------------------------------------------------------
    initial
    begin
        void'($urandom(SEED));
        clk           = 1'b0;
        rst           = 1'b1;
        adr           = '0;
        cyc           = 1'b0;
        stb           = 1'b0;
        we            = 1'b0;
        rd            = 1'b0;
        byte_stb      = 4'h0;
        dat_i         = '0;
        gpio_in       = 8'h00;
        checks        = 0;
        errors        = 0;
        tests_run     = 0;
        tests_failed  = 0;
        assert_errors = 0;
        repeat (5) @(negedge clk);
        rst = 1'b0;

        run_vector_table();
        gpio_pin_test();
        fifo_order_test("fifo1_order", FIFO1_ACC_ADR, 32'h0000_FFFF, 6);
        fifo_order_test("fifo3_order", FIFO3_ACC_ADR, 32'hFFFF_FFFF, 6);
        fifo2_flag_test();
        fifo1_overflow_test();

        assert_errors = uut.u_regs.u_asserts.failures;
        $display("%0d tests run, %0d failed, %0d checks, %0d errors, %0d assertion failures",
                 tests_run, tests_failed, checks, errors, assert_errors);
        if (errors == 0 && assert_errors == 0)
            $display("TESTS PASSED");
        else
            $display("TESTS FAILED");
        $finish;
    end

endmodule

// File: verification/fpga_subsystem_asserts.sv
//----------------------------------------------------------------------
// Bus handshake and pop strobe assertions
//----------------------------------------------------------------------
module fpga_subsystem_asserts (
    input logic       clk_i,
    input logic       rst_i,
    input logic       cyc_i,
    input logic       stb_i,
    input logic       ack_i,
    input logic [2:0] pop_i     // Bit n is FIFO n+1
);

    int failures = 0;           // Count of failed assertions

    // ACK lasts exactly one cycle
    assert property (@(posedge clk_i) disable iff (rst_i) ack_i |=> !ack_i)
        else
        begin
            $error("ACK held high for two cycles");
            failures++;
        end

    // ACK only for an access accepted on the previous edge
    assert property (@(posedge clk_i) disable iff (rst_i)
                     ack_i |-> $past(cyc_i && stb_i && !ack_i))
        else
        begin
            $error("ACK without an accepted access");
            failures++;
        end

    //------------------------------------------------------------------
    // Pop strobes
    //------------------------------------------------------------------
    assert property (@(posedge clk_i) disable iff (rst_i) pop_i[0] |=> !pop_i[0])
        else
        begin
            $error("FIFO1 pop strobe longer than one cycle");
            failures++;
        end
    assert property (@(posedge clk_i) disable iff (rst_i) pop_i[1] |=> !pop_i[1])
        else
        begin
            $error("FIFO2 pop strobe longer than one cycle");
            failures++;
        end
    assert property (@(posedge clk_i) disable iff (rst_i) pop_i[2] |=> !pop_i[2])
        else
        begin
            $error("FIFO3 pop strobe longer than one cycle");
            failures++;
        end

endmodule

bind fpga_registers fpga_subsystem_asserts u_asserts (
    .clk_i (WBs_CLK_i),
    .rst_i (WBs_RST_i),
    .cyc_i (WBs_CYC_i),
    .stb_i (WBs_STB_i),
    .ack_i (WBs_ACK_o),
    .pop_i ({fifo3_pop_o, fifo2_pop_o, fifo1_pop_o})
);

// File: hw/fpga_subsystem_top.sv
//----------------------------------------------------------------------
// Register and FIFO subsystem top
//----------------------------------------------------------------------
module fpga_subsystem_top #(
    parameter int FIFO1_DEPTH = 512,
    parameter int FIFO2_DEPTH = 1024,
    parameter int FIFO3_DEPTH = 512
) (
    input  logic                                 WBs_CLK_i,
    input  logic                                 WBs_RST_i,
    input  logic [fpga_regs_pkg::ADDR_WIDTH-1:0] WBs_ADR_i,
    input  logic                                 WBs_CYC_i,
    input  logic [3:0]                           WBs_BYTE_STB_i,
    input  logic                                 WBs_WE_i,
    input  logic                                 WBs_RD_i,
    input  logic                                 WBs_STB_i,
    input  logic [fpga_regs_pkg::DATA_WIDTH-1:0] WBs_DAT_i,
    output logic [fpga_regs_pkg::DATA_WIDTH-1:0] WBs_DAT_o,
    output logic                                 WBs_ACK_o,
    input  logic [7:0]                           gpio_in_i,
    output logic [7:0]                           gpio_out_o,
    output logic [7:0]                           gpio_oe_o
);
    import fpga_regs_pkg::*;

    // FIFO n is at index n
    logic [15:0]                fifo1_dout;
    logic [15:0]                fifo2_dout;
    logic [31:0]                fifo3_dout;
    logic [FIFO_FLAG_WIDTH-1:0] push_flag [1:3];
    logic [FIFO_FLAG_WIDTH-1:0] pop_flag  [1:3];
    logic                       almost_full  [1:3];
    logic                       almost_empty [1:3];
    logic                       push [1:3];
    logic                       pop  [1:3];

    fpga_registers u_regs (
        .WBs_CLK_i            (WBs_CLK_i),
        .WBs_RST_i            (WBs_RST_i),
        .WBs_ADR_i            (WBs_ADR_i),
        .WBs_CYC_i            (WBs_CYC_i),
        .WBs_BYTE_STB_i       (WBs_BYTE_STB_i),
        .WBs_WE_i             (WBs_WE_i),
        .WBs_RD_i             (WBs_RD_i),
        .WBs_STB_i            (WBs_STB_i),
        .WBs_DAT_i            (WBs_DAT_i),
        .WBs_DAT_o            (WBs_DAT_o),
        .WBs_ACK_o            (WBs_ACK_o),
        .gpio_in_i            (gpio_in_i),
        .gpio_out_o           (gpio_out_o),
        .gpio_oe_o            (gpio_oe_o),
        .fifo1_dout_i         (fifo1_dout),
        .fifo2_dout_i         (fifo2_dout),
        .fifo3_dout_i         (fifo3_dout),
        .fifo1_push_flag_i    (push_flag[1]),
        .fifo1_pop_flag_i     (pop_flag[1]),
        .fifo2_push_flag_i    (push_flag[2]),
        .fifo2_pop_flag_i     (pop_flag[2]),
        .fifo3_push_flag_i    (push_flag[3]),
        .fifo3_pop_flag_i     (pop_flag[3]),
        .fifo1_almost_full_i  (almost_full[1]),
        .fifo1_almost_empty_i (almost_empty[1]),
        .fifo2_almost_full_i  (almost_full[2]),
        .fifo2_almost_empty_i (almost_empty[2]),
        .fifo3_almost_full_i  (almost_full[3]),
        .fifo3_almost_empty_i (almost_empty[3]),
        .fifo1_push_o         (push[1]),
        .fifo2_push_o         (push[2]),
        .fifo3_push_o         (push[3]),
        .fifo1_pop_o          (pop[1]),
        .fifo2_pop_o          (pop[2]),
        .fifo3_pop_o          (pop[3])
    );

    //------------------------------------------------------------------
    // FIFOs
    //------------------------------------------------------------------
    sync_fifo #(.WIDTH(16), .DEPTH(FIFO1_DEPTH)) u_fifo1 (
        .WBs_CLK_i      (WBs_CLK_i),
        .WBs_RST_i      (WBs_RST_i),
        .push_i         (push[1]),
        .pop_i          (pop[1]),
        .din_i          (WBs_DAT_i[15:0]),  // Low half only
        .dout_o         (fifo1_dout),
        .push_flag_o    (push_flag[1]),
        .pop_flag_o     (pop_flag[1]),
        .almost_full_o  (almost_full[1]),
        .almost_empty_o (almost_empty[1])
    );

    sync_fifo #(.WIDTH(16), .DEPTH(FIFO2_DEPTH)) u_fifo2 (
        .WBs_CLK_i      (WBs_CLK_i),
        .WBs_RST_i      (WBs_RST_i),
        .push_i         (push[2]),
        .pop_i          (pop[2]),
        .din_i          (WBs_DAT_i[15:0]),
        .dout_o         (fifo2_dout),
        .push_flag_o    (push_flag[2]),
        .pop_flag_o     (pop_flag[2]),
        .almost_full_o  (almost_full[2]),
        .almost_empty_o (almost_empty[2])
    );

    sync_fifo #(.WIDTH(32), .DEPTH(FIFO3_DEPTH)) u_fifo3 (
        .WBs_CLK_i      (WBs_CLK_i),
        .WBs_RST_i      (WBs_RST_i),
        .push_i         (push[3]),
        .pop_i          (pop[3]),
        .din_i          (WBs_DAT_i),
        .dout_o         (fifo3_dout),
        .push_flag_o    (push_flag[3]),
        .pop_flag_o     (pop_flag[3]),
        .almost_full_o  (almost_full[3]),
        .almost_empty_o (almost_empty[3])
    );

endmodule

// File: fpga_registers/fpga_registers.sv
//----------------------------------------------------------------------
// Bus slave register block
//----------------------------------------------------------------------
module fpga_registers (
    input  logic                                  WBs_CLK_i,
    input  logic                                  WBs_RST_i,

    // Bridge side
    input  logic [fpga_regs_pkg::ADDR_WIDTH-1:0]  WBs_ADR_i,
    input  logic                                  WBs_CYC_i,
    input  logic [3:0]                            WBs_BYTE_STB_i,
    input  logic                                  WBs_WE_i,
    input  logic                                  WBs_RD_i,
    input  logic                                  WBs_STB_i,
    input  logic [fpga_regs_pkg::DATA_WIDTH-1:0]  WBs_DAT_i,
    output logic [fpga_regs_pkg::DATA_WIDTH-1:0]  WBs_DAT_o,
    output logic                                  WBs_ACK_o,

    // GPIO
    input  logic [7:0]                            gpio_in_i,
    output logic [7:0]                            gpio_out_o,
    output logic [7:0]                            gpio_oe_o,

    // FIFO side
    input  logic [15:0]                           fifo1_dout_i,
    input  logic [15:0]                           fifo2_dout_i,
    input  logic [31:0]                           fifo3_dout_i,
    input  logic [fpga_regs_pkg::FIFO_FLAG_WIDTH-1:0] fifo1_push_flag_i,
    input  logic [fpga_regs_pkg::FIFO_FLAG_WIDTH-1:0] fifo1_pop_flag_i,
    input  logic [fpga_regs_pkg::FIFO_FLAG_WIDTH-1:0] fifo2_push_flag_i,
    input  logic [fpga_regs_pkg::FIFO_FLAG_WIDTH-1:0] fifo2_pop_flag_i,
    input  logic [fpga_regs_pkg::FIFO_FLAG_WIDTH-1:0] fifo3_push_flag_i,
    input  logic [fpga_regs_pkg::FIFO_FLAG_WIDTH-1:0] fifo3_pop_flag_i,
    input  logic                                  fifo1_almost_full_i,
    input  logic                                  fifo1_almost_empty_i,
    input  logic                                  fifo2_almost_full_i,
    input  logic                                  fifo2_almost_empty_i,
    input  logic                                  fifo3_almost_full_i,
    input  logic                                  fifo3_almost_empty_i,
    output logic                                  fifo1_push_o,
    output logic                                  fifo2_push_o,
    output logic                                  fifo3_push_o,
    output logic                                  fifo1_pop_o,
    output logic                                  fifo2_pop_o,
    output logic                                  fifo3_pop_o
);
    import fpga_regs_pkg::*;

    logic       access;     // Cycle accepted on this edge
    logic [2:0] wr_dcd;     // Bit n is FIFO n+1
    logic [2:0] rd_dcd;
    logic [2:0] rd_s0;      // Read decode shift stages
    logic [2:0] rd_s1;
    logic [2:0] rd_s2;
    logic [2:0] pop_stb;

    // Status word as seen by the host
    function automatic logic [DATA_WIDTH-1:0] flag_word(
        input logic [FIFO_FLAG_WIDTH-1:0] push_flag,
        input logic [FIFO_FLAG_WIDTH-1:0] pop_flag,
        input logic                       almost_full,
        input logic                       almost_empty
    );
        return {16'h0000, almost_empty, 3'b000, pop_flag,
                almost_full, 3'b000, push_flag};
    endfunction

    //------------------------------------------------------------------
    // Decode
    //------------------------------------------------------------------
    assign access = WBs_CYC_i & WBs_STB_i & ~WBs_ACK_o;

    assign wr_dcd[0] = access &  WBs_WE_i & (WBs_ADR_i == FIFO1_ACC_ADR);
    assign wr_dcd[1] = access &  WBs_WE_i & (WBs_ADR_i == FIFO2_ACC_ADR);
    assign wr_dcd[2] = access &  WBs_WE_i & (WBs_ADR_i == FIFO3_ACC_ADR);
    assign rd_dcd[0] = access & ~WBs_WE_i & (WBs_ADR_i == FIFO1_ACC_ADR);
    assign rd_dcd[1] = access & ~WBs_WE_i & (WBs_ADR_i == FIFO2_ACC_ADR);
    assign rd_dcd[2] = access & ~WBs_WE_i & (WBs_ADR_i == FIFO3_ACC_ADR);

    assign fifo1_push_o = wr_dcd[0];
    assign fifo2_push_o = wr_dcd[1];
    assign fifo3_push_o = wr_dcd[2];

    // Pop after the host has sampled the head word
    assign pop_stb     = rd_s1 & ~rd_s2;
    assign fifo1_pop_o = pop_stb[0];
    assign fifo2_pop_o = pop_stb[1];
    assign fifo3_pop_o = pop_stb[2];

    //------------------------------------------------------------------
    // Acknowledge, GPIO registers, pop pipeline
    //------------------------------------------------------------------
    always_ff @(posedge WBs_CLK_i or posedge WBs_RST_i)
    begin
        if (WBs_RST_i)
        begin
            WBs_ACK_o  <= 1'b0;
            gpio_out_o <= GPIO_OUT_RESET;
            gpio_oe_o  <= GPIO_OE_RESET;
            rd_s0      <= 3'b000;
            rd_s1      <= 3'b000;
            rd_s2      <= 3'b000;
        end
        else
        begin
            WBs_ACK_o <= access;  // Single cycle, access drops while ACK is high

            if (access && WBs_WE_i && WBs_BYTE_STB_i[0])
            begin
                if (WBs_ADR_i == GPIO_OUT_ADR)
                    gpio_out_o <= WBs_DAT_i[7:0];
                if (WBs_ADR_i == GPIO_OE_ADR)
                    gpio_oe_o <= WBs_DAT_i[7:0];
            end

            rd_s0 <= rd_dcd;
            rd_s1 <= rd_s0;
            rd_s2 <= rd_s1;
        end
    end

    //------------------------------------------------------------------
    // Read multiplexer
    //------------------------------------------------------------------
    always_comb
    begin
        case (WBs_ADR_i)
            REG_ID_ADR:     WBs_DAT_o = DEVICE_ID;
            REG_REV_ADR:    WBs_DAT_o = {16'h0000, REV_NUM};
            GPIO_IN_ADR:    WBs_DAT_o = {24'h000000, gpio_in_i};
            GPIO_OUT_ADR:   WBs_DAT_o = {24'h000000, gpio_out_o};
            GPIO_OE_ADR:    WBs_DAT_o = {24'h000000, gpio_oe_o};
            FIFO1_ACC_ADR:  WBs_DAT_o = {16'h0000, fifo1_dout_i};
            FIFO1_FLAG_ADR: WBs_DAT_o = flag_word(fifo1_push_flag_i, fifo1_pop_flag_i,
                                                  fifo1_almost_full_i, fifo1_almost_empty_i);
            FIFO2_ACC_ADR:  WBs_DAT_o = {16'h0000, fifo2_dout_i};
            FIFO2_FLAG_ADR: WBs_DAT_o = flag_word(fifo2_push_flag_i, fifo2_pop_flag_i,
                                                  fifo2_almost_full_i, fifo2_almost_empty_i);
            FIFO3_ACC_ADR:  WBs_DAT_o = fifo3_dout_i;
            FIFO3_FLAG_ADR: WBs_DAT_o = flag_word(fifo3_push_flag_i, fifo3_pop_flag_i,
                                                  fifo3_almost_full_i, fifo3_almost_empty_i);
            default:        WBs_DAT_o = DEFAULT_READ_VALUE;
        endcase
    end

endmodule

// File: fifo/sync_fifo.sv
//----------------------------------------------------------------------
// Single-clock FWFT FIFO
//----------------------------------------------------------------------
module sync_fifo #(
    parameter int WIDTH = 16,
    parameter int DEPTH = 512
) (
    input  logic                                      WBs_CLK_i,
    input  logic                                      WBs_RST_i,
    input  logic                                      push_i,
    input  logic                                      pop_i,
    input  logic [WIDTH-1:0]                          din_i,
    output logic [WIDTH-1:0]                          dout_o,
    output logic [fpga_regs_pkg::FIFO_FLAG_WIDTH-1:0] push_flag_o,
    output logic [fpga_regs_pkg::FIFO_FLAG_WIDTH-1:0] pop_flag_o,
    output logic                                      almost_full_o,
    output logic                                      almost_empty_o
);
    localparam int AW = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CW = $clog2(DEPTH + 1);

    localparam logic [AW-1:0] LAST_SLOT = AW'(DEPTH - 1);
    localparam logic [CW-1:0] FULL_CNT  = CW'(DEPTH);

    logic [WIDTH-1:0] mem [DEPTH];
    logic [AW-1:0]    wr_ptr;
    logic [AW-1:0]    rd_ptr;
    logic [CW-1:0]    count;    // Entries held
    logic             do_push;
    logic             do_pop;

    // Overflow and underflow are dropped silently
    assign do_push = push_i && (count != FULL_CNT);
    assign do_pop  = pop_i  && (count != '0);

    assign dout_o = mem[rd_ptr];  // Head word, no read latency

    //------------------------------------------------------------------
    // Storage
    //------------------------------------------------------------------
    always_ff @(posedge WBs_CLK_i)
    begin
        if (do_push)
            mem[wr_ptr] <= din_i;
    end

    //------------------------------------------------------------------
    // Pointers and occupancy
    //------------------------------------------------------------------
    always_ff @(posedge WBs_CLK_i or posedge WBs_RST_i)
    begin
        if (WBs_RST_i)
        begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end
        else
        begin
            if (do_push)
                wr_ptr <= (wr_ptr == LAST_SLOT) ? '0 : wr_ptr + 1'b1;
            if (do_pop)
                rd_ptr <= (rd_ptr == LAST_SLOT) ? '0 : rd_ptr + 1'b1;

            case ({do_push, do_pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;  // Idle or push and pop together
            endcase
        end
    end

    fifo_level_flags #(
        .DEPTH          (DEPTH)
    ) u_level_flags (
        .count_i        (count),
        .push_flag_o    (push_flag_o),
        .pop_flag_o     (pop_flag_o),
        .almost_full_o  (almost_full_o),
        .almost_empty_o (almost_empty_o)
    );

endmodule

// File: fifo/fifo_level_flags.sv
//----------------------------------------------------------------------
// FIFO fill-level flag encoder
//----------------------------------------------------------------------
module fifo_level_flags #(
    parameter int DEPTH = 512
) (
    input  logic [$clog2(DEPTH+1)-1:0]                count_i,
    output logic [fpga_regs_pkg::FIFO_FLAG_WIDTH-1:0] push_flag_o,
    output logic [fpga_regs_pkg::FIFO_FLAG_WIDTH-1:0] pop_flag_o,
    output logic                                      almost_full_o,
    output logic                                      almost_empty_o
);
    import fpga_regs_pkg::*;

    localparam int CW = $clog2(DEPTH + 1);

    logic [CW-1:0] free_slots;

    // Same thresholds for entries held and for free space
    function automatic logic [FIFO_FLAG_WIDTH-1:0] level_code(input int unsigned n);
        if (n >= DEPTH)
            return LVL_ALL;
        else if (4 * n >= 3 * DEPTH)
            return LVL_THREE_Q;
        else if (2 * n >= DEPTH)
            return LVL_HALF;
        else if (4 * n >= DEPTH)
            return LVL_QUARTER;
        else if (n != 0)
            return LVL_SOME;
        else
            return LVL_NONE;
    endfunction

    assign free_slots = CW'(DEPTH) - count_i;

    assign pop_flag_o     = level_code(count_i);
    assign push_flag_o    = level_code(free_slots);
    assign almost_full_o  = (free_slots <= 1);   // One slot left or none
    assign almost_empty_o = (count_i <= 1);

endmodule

// File: common/fpga_regs_pkg.sv
//----------------------------------------------------------------------
// Register map and shared constants
//----------------------------------------------------------------------
package fpga_regs_pkg;

    // Bus geometry
    localparam int ADDR_WIDTH = 9;
    localparam int DATA_WIDTH = 32;

    //------------------------------------------------------------------
    // Register map
    //------------------------------------------------------------------
    localparam logic [ADDR_WIDTH-1:0] REG_ID_ADR     = 9'h000;
    localparam logic [ADDR_WIDTH-1:0] REG_REV_ADR    = 9'h001;
    localparam logic [ADDR_WIDTH-1:0] GPIO_IN_ADR    = 9'h002;
    localparam logic [ADDR_WIDTH-1:0] GPIO_OUT_ADR   = 9'h003;
    localparam logic [ADDR_WIDTH-1:0] GPIO_OE_ADR    = 9'h004;

    localparam logic [ADDR_WIDTH-1:0] FIFO1_ACC_ADR  = 9'h040;
    localparam logic [ADDR_WIDTH-1:0] FIFO1_FLAG_ADR = 9'h041;
    localparam logic [ADDR_WIDTH-1:0] FIFO2_ACC_ADR  = 9'h080;
    localparam logic [ADDR_WIDTH-1:0] FIFO2_FLAG_ADR = 9'h081;
    localparam logic [ADDR_WIDTH-1:0] FIFO3_ACC_ADR  = 9'h100;
    localparam logic [ADDR_WIDTH-1:0] FIFO3_FLAG_ADR = 9'h101;

    //------------------------------------------------------------------
    // Identity and reset values
    //------------------------------------------------------------------
    localparam logic [31:0] DEVICE_ID          = 32'hF1F0_7E57;
    localparam logic [15:0] REV_NUM            = 16'h0100;       // Zero-extended on read
    localparam logic [31:0] DEFAULT_READ_VALUE = 32'hFABD_EFAC;  // Unmapped addresses

    localparam logic [7:0]  GPIO_OUT_RESET     = 8'h00;
    localparam logic [7:0]  GPIO_OE_RESET      = 8'h00;

    //------------------------------------------------------------------
    // FIFO fill-level codes
    //------------------------------------------------------------------
    localparam int FIFO_FLAG_WIDTH = 4;

    localparam logic [FIFO_FLAG_WIDTH-1:0] LVL_NONE    = 4'd0;  // Nothing present
    localparam logic [FIFO_FLAG_WIDTH-1:0] LVL_SOME    = 4'd1;  // One or more
    localparam logic [FIFO_FLAG_WIDTH-1:0] LVL_QUARTER = 4'd2;
    localparam logic [FIFO_FLAG_WIDTH-1:0] LVL_HALF    = 4'd3;
    localparam logic [FIFO_FLAG_WIDTH-1:0] LVL_THREE_Q = 4'd4;
    localparam logic [FIFO_FLAG_WIDTH-1:0] LVL_ALL     = 4'd5;  // Whole depth

endpackage
